// File: rtl/lsu_pkg.sv
// LSU shared definitions
package lsu_pkg;

    // Memory operation, funct3-like low bits, bit 3 marks a store.
    typedef enum logic [3:0] {
        LB  = 4'b0000,
        LH  = 4'b0001,
        LW  = 4'b0010,
        LBU = 4'b0100,
        LHU = 4'b0101,
        SB  = 4'b1000,
        SH  = 4'b1001,
        SW  = 4'b1010
    } lsu_op_e;

    // One data word, seen whole or as byte lanes.
    typedef union packed {
        logic [31:0]     word;
        logic [3:0][7:0] lane;
    } lsu_word_u;

    localparam logic [4:0] CAUSE_LD_MISALIGN = 5'd4;
    localparam logic [4:0] CAUSE_LD_FAULT    = 5'd5;
    localparam logic [4:0] CAUSE_ST_MISALIGN = 5'd6;

    function automatic logic op_is_store(input lsu_op_e op);
        return op inside {SB, SH, SW};
    endfunction

    function automatic logic [2:0] op_size(input lsu_op_e op);
        case (op)
            LB, LBU, SB: return 3'd1;
            LH, LHU, SH: return 3'd2;
            default:     return 3'd4;
        endcase
    endfunction

    function automatic logic op_aligned(input lsu_op_e op, input logic [1:0] addr_lo);
        case (op_size(op))
            3'd1:    return 1'b1;
            3'd2:    return ~addr_lo[0];
            default: return addr_lo == 2'b00;
        endcase
    endfunction

endpackage

// File: rtl/lsu_agu_if.sv
// Address stage to load unit link
`timescale 1ns/10ps

interface lsu_agu_if import lsu_pkg::*; #(
    parameter int XLEN          = 32,
    parameter int PLEN          = 32,
    parameter int ROB_IDX_WIDTH = 6,
    parameter int SB_ID_WIDTH   = 4
) ();

    logic                     valid;
    logic                     ready;
    logic [PLEN-1:0]          addr;
    lsu_op_e                  op;
    logic [ROB_IDX_WIDTH-1:0] rob_idx;
    logic                     exc;    // Misaligned access.

    // Data path is built on the 32-bit word union.
    if (XLEN != 32 || SB_ID_WIDTH < 1) begin : g_param_check
        $error("lsu_agu_if: XLEN must be 32 and SB_ID_WIDTH at least 1");
    end

    modport agu (output valid, addr, op, rob_idx, exc, input ready);
    modport load (input valid, addr, op, rob_idx, exc, output ready);

endinterface

// File: rtl/lsu_wb_if.sv
// Load unit to writeback link
`timescale 1ns/10ps

interface lsu_wb_if #(
    parameter int XLEN          = 32,
    parameter int PLEN          = 32,
    parameter int ROB_IDX_WIDTH = 6,
    parameter int SB_ID_WIDTH   = 4
) ();

    logic                     valid;
    logic                     ready;
    logic [ROB_IDX_WIDTH-1:0] rob_idx;
    logic [XLEN-1:0]          data;
    logic                     exception;
    logic [4:0]               ecause;

    if (PLEN < 2 || SB_ID_WIDTH < 1) begin : g_param_check
        $error("lsu_wb_if: PLEN must be at least 2 and SB_ID_WIDTH at least 1");
    end

    modport src (output valid, rob_idx, data, exception, ecause, input ready);
    modport dst (input valid, rob_idx, data, exception, ecause, output ready);

endinterface

// File: rtl/lsu_agu.sv
// LSU address generation stage
`timescale 1ns/10ps

module lsu_agu import lsu_pkg::*; #(
    parameter int XLEN          = 32,
    parameter int PLEN          = 32,
    parameter int ROB_IDX_WIDTH = 6,
    parameter int SB_ID_WIDTH   = 4
) (
    input  logic                     clk_i,
    input  logic                     arst_n_i,
    input  logic                     flush_i,

    input  logic                     req_valid_i,
    output logic                     req_ready_o,
    input  lsu_op_e                  op_i,
    input  logic [XLEN-1:0]          imm_i,
    input  logic [XLEN-1:0]          rs1_data_i,
    input  logic [XLEN-1:0]          rs2_data_i,
    input  logic [ROB_IDX_WIDTH-1:0] rob_tag_i,
    input  logic [SB_ID_WIDTH-1:0]   sb_id_i,

    output logic                     sb_ex_valid_o,
    output logic [SB_ID_WIDTH-1:0]   sb_ex_sb_id_o,
    output logic [PLEN-1:0]          sb_ex_addr_o,
    output logic [XLEN-1:0]          sb_ex_data_o,
    output lsu_op_e                  sb_ex_op_o,

    lsu_agu_if.agu                   agu
);

    logic [XLEN-1:0]          sum;
    logic [PLEN-1:0]          eff_addr;
    logic                     aligned;
    logic                     req_fire;

    logic                     valid_q;
    logic                     sb_ex_valid_q;
    logic [PLEN-1:0]          addr_q;
    lsu_op_e                  op_q;
    logic [ROB_IDX_WIDTH-1:0] rob_q;
    logic                     exc_q;
    logic [SB_ID_WIDTH-1:0]   sb_id_q;
    logic [XLEN-1:0]          data_q;

    assign sum      = rs1_data_i + imm_i;
    assign eff_addr = PLEN'(sum);
    assign aligned  = op_aligned(op_i, eff_addr[1:0]);

    // Take a new request when empty or being emptied.
    assign req_ready_o = ~valid_q | agu.ready;
    assign req_fire    = req_valid_i & req_ready_o;

    // ********************
    // Stage control
    // ********************

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q       <= 1'b0;
            sb_ex_valid_q <= 1'b0;
        end else if (flush_i) begin
            valid_q       <= 1'b0;
            sb_ex_valid_q <= 1'b0;
        end else begin
            sb_ex_valid_q <= req_fire & op_is_store(op_i) & aligned;  // One pulse per store.
            if (req_fire) begin
                valid_q <= 1'b1;
            end else if (agu.ready) begin
                valid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (req_fire) begin
            addr_q  <= eff_addr;
            op_q    <= op_i;
            rob_q   <= rob_tag_i;
            exc_q   <= ~aligned;
            sb_id_q <= sb_id_i;
            data_q  <= rs2_data_i;
        end
    end

    assign agu.valid   = valid_q;
    assign agu.addr    = addr_q;
    assign agu.op      = op_q;
    assign agu.rob_idx = rob_q;
    assign agu.exc     = exc_q;

    // Store buffer execute write.
    assign sb_ex_valid_o = sb_ex_valid_q;
    assign sb_ex_sb_id_o = sb_id_q;
    assign sb_ex_addr_o  = addr_q;
    assign sb_ex_data_o  = data_q;
    assign sb_ex_op_o    = op_q;

endmodule

// File: rtl/lsu_load_unit.sv
// LSU load processing
`timescale 1ns/10ps

module lsu_load_unit import lsu_pkg::*; #(
    parameter int XLEN          = 32,
    parameter int PLEN          = 32,
    parameter int ROB_IDX_WIDTH = 6,
    parameter int SB_ID_WIDTH   = 4
) (
    input  logic            clk_i,
    input  logic            arst_n_i,
    input  logic            flush_i,
    lsu_agu_if.load         agu,

    output logic [PLEN-1:0] sb_load_addr_o,
    input  logic            sb_load_hit_i,
    input  logic [XLEN-1:0] sb_load_data_i,

    output logic            ld_req_valid_o,
    input  logic            ld_req_ready_i,
    output logic [PLEN-1:0] ld_req_addr_o,
    output lsu_op_e         ld_req_op_o,

    input  logic            ld_rsp_valid_i,
    output logic            ld_rsp_ready_o,
    input  logic [XLEN-1:0] ld_rsp_data_i,
    input  logic            ld_rsp_err_i,

    lsu_wb_if.src           wb
);

    localparam logic [1:0] ST_IDLE = 2'd0;
    localparam logic [1:0] ST_REQ  = 2'd1;
    localparam logic [1:0] ST_RSP  = 2'd2;

    logic [1:0]               state_q;
    logic                     drain_q, drain_d;
    logic                     room, take_item, imm_done, miss, rsp_take;
    lsu_word_u                fwd_word, rsp_word;

    logic [PLEN-1:0]          ld_addr_q;
    lsu_op_e                  ld_op_q;
    logic [ROB_IDX_WIDTH-1:0] ld_rob_q;

    logic                     res_valid_q, res_load;
    logic [ROB_IDX_WIDTH-1:0] res_rob_q, res_rob_d;
    logic [XLEN-1:0]          res_data_q, res_data_d;
    logic                     res_exc_q, res_exc_d;
    logic [4:0]               res_cause_q, res_cause_d;

    if (XLEN != 32 || SB_ID_WIDTH < 1) begin : g_param_check
        $error("lsu_load_unit: XLEN must be 32 and SB_ID_WIDTH at least 1");
    end

    // Byte or half select by offset, then extension by op.
    function automatic logic [31:0] extract(input lsu_op_e op, input logic [1:0] off,
                                            input lsu_word_u w);
        logic [7:0]  b;
        logic [15:0] h;
        b = w.lane[off];
        h = off[1] ? {w.lane[3], w.lane[2]} : {w.lane[1], w.lane[0]};
        case (op)
            LB:      return {{24{b[7]}}, b};
            LBU:     return {24'b0, b};
            LH:      return {{16{h[15]}}, h};
            LHU:     return {16'b0, h};
            default: return w.word;
        endcase
    endfunction

    assign fwd_word = sb_load_data_i;
    assign rsp_word = ld_rsp_data_i;

    assign room      = ~res_valid_q | wb.ready;
    assign agu.ready = (state_q == ST_IDLE) & room;
    assign take_item = agu.valid & agu.ready;
    assign imm_done  = take_item & (agu.exc | op_is_store(agu.op) | sb_load_hit_i);
    assign miss      = take_item & ~imm_done;

    assign sb_load_addr_o = {agu.addr[PLEN-1:2], 2'b00};  // Word granular match.
    assign ld_req_valid_o = state_q == ST_REQ;
    assign ld_req_addr_o  = ld_addr_q;
    assign ld_req_op_o    = ld_op_q;
    assign ld_rsp_ready_o = drain_q | ((state_q == ST_RSP) & room);
    assign rsp_take       = ld_rsp_valid_i & ~drain_q & (state_q == ST_RSP) & room;

    // A flushed load with an accepted request still owes a response.
    always_comb begin
        drain_d = drain_q;
        if (drain_q && ld_rsp_valid_i) begin
            drain_d = 1'b0;
        end
        if (flush_i && (((state_q == ST_REQ) && ld_req_ready_i) ||
                        ((state_q == ST_RSP) && !rsp_take))) begin
            drain_d = 1'b1;
        end
    end

    always_comb begin
        res_load    = 1'b0;
        res_rob_d   = agu.rob_idx;
        res_data_d  = '0;
        res_exc_d   = 1'b0;
        res_cause_d = '0;
        if (imm_done) begin
            res_load = 1'b1;
            if (agu.exc) begin
                res_exc_d   = 1'b1;
                res_cause_d = op_is_store(agu.op) ? CAUSE_ST_MISALIGN : CAUSE_LD_MISALIGN;
            end else if (!op_is_store(agu.op)) begin
                res_data_d = extract(agu.op, agu.addr[1:0], fwd_word);  // Forwarded.
            end
        end else if (rsp_take) begin
            res_load  = 1'b1;
            res_rob_d = ld_rob_q;
            if (ld_rsp_err_i) begin
                res_exc_d   = 1'b1;
                res_cause_d = CAUSE_LD_FAULT;
            end else begin
                res_data_d = extract(ld_op_q, ld_addr_q[1:0], rsp_word);
            end
        end
    end

    // ********************
    // FSM and result register
    // ********************

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q     <= ST_IDLE;
            drain_q     <= 1'b0;
            res_valid_q <= 1'b0;
        end else begin
            drain_q <= drain_d;
            if (flush_i) begin
                state_q     <= ST_IDLE;
                res_valid_q <= 1'b0;
            end else begin
                case (state_q)
                    ST_IDLE: if (miss) state_q <= ST_REQ;
                    ST_REQ:  if (ld_req_ready_i) state_q <= ST_RSP;
                    ST_RSP:  if (rsp_take) state_q <= ST_IDLE;
                    default: state_q <= ST_IDLE;
                endcase
                if (res_load) begin
                    res_valid_q <= 1'b1;
                end else if (wb.ready) begin
                    res_valid_q <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (miss) begin
            ld_addr_q <= agu.addr;
            ld_op_q   <= agu.op;
            ld_rob_q  <= agu.rob_idx;
        end
        if (res_load) begin
            res_rob_q   <= res_rob_d;
            res_data_q  <= res_data_d;
            res_exc_q   <= res_exc_d;
            res_cause_q <= res_cause_d;
        end
    end

    assign wb.valid     = res_valid_q;
    assign wb.rob_idx   = res_rob_q;
    assign wb.data      = res_data_q;
    assign wb.exception = res_exc_q;
    assign wb.ecause    = res_cause_q;

endmodule

// File: rtl/lsu_writeback.sv
// LSU writeback output register
`timescale 1ns/10ps

module lsu_writeback #(
    parameter int XLEN          = 32,
    parameter int PLEN          = 32,
    parameter int ROB_IDX_WIDTH = 6,
    parameter int SB_ID_WIDTH   = 4
) (
    input  logic                     clk_i,
    input  logic                     arst_n_i,
    input  logic                     flush_i,
    lsu_wb_if.dst                    wb,

    output logic                     wb_valid_o,
    output logic [ROB_IDX_WIDTH-1:0] wb_rob_idx_o,
    output logic [XLEN-1:0]          wb_data_o,
    output logic                     wb_exception_o,
    output logic [4:0]               wb_ecause_o,
    input  logic                     wb_ready_i
);

    logic valid_q;
    logic load;

    if (PLEN < 2 || SB_ID_WIDTH < 1) begin : g_param_check
        $error("lsu_writeback: PLEN must be at least 2 and SB_ID_WIDTH at least 1");
    end

    // Free when empty or the ROB takes the current result.
    assign wb.ready = ~valid_q | wb_ready_i;
    assign load     = wb.valid & wb.ready;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q <= 1'b0;
        end else if (flush_i) begin
            valid_q <= 1'b0;
        end else if (load) begin
            valid_q <= 1'b1;
        end else if (wb_ready_i) begin
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (load) begin
            wb_rob_idx_o   <= wb.rob_idx;
            wb_data_o      <= wb.data;
            wb_exception_o <= wb.exception;
            wb_ecause_o    <= wb.ecause;
        end
    end

    assign wb_valid_o = valid_q;

endmodule

// File: rtl/lsu_top.sv
// Load/store unit top level
`timescale 1ns/10ps

module lsu_top import lsu_pkg::*; #(
    parameter int XLEN          = 32,
    parameter int PLEN          = 32,
    parameter int ROB_IDX_WIDTH = 6,
    parameter int SB_ID_WIDTH   = 4
) (
    input  logic                     clk_i,
    input  logic                     arst_n_i,
    input  logic                     flush_i,

    // Request.
    input  logic                     req_valid_i,
    output logic                     req_ready_o,
    input  lsu_op_e                  op_i,
    input  logic [XLEN-1:0]          imm_i,
    input  logic [XLEN-1:0]          rs1_data_i,
    input  logic [XLEN-1:0]          rs2_data_i,
    input  logic [ROB_IDX_WIDTH-1:0] rob_tag_i,
    input  logic [SB_ID_WIDTH-1:0]   sb_id_i,

    // Store buffer execute write.
    output logic                     sb_ex_valid_o,
    output logic [SB_ID_WIDTH-1:0]   sb_ex_sb_id_o,
    output logic [PLEN-1:0]          sb_ex_addr_o,
    output logic [XLEN-1:0]          sb_ex_data_o,
    output lsu_op_e                  sb_ex_op_o,

    // Store-to-load forwarding.
    output logic [PLEN-1:0]          sb_load_addr_o,
    input  logic                     sb_load_hit_i,
    input  logic [XLEN-1:0]          sb_load_data_i,

    // Data cache load port.
    output logic                     ld_req_valid_o,
    input  logic                     ld_req_ready_i,
    output logic [PLEN-1:0]          ld_req_addr_o,
    output lsu_op_e                  ld_req_op_o,
    input  logic                     ld_rsp_valid_i,
    output logic                     ld_rsp_ready_o,
    input  logic [XLEN-1:0]          ld_rsp_data_i,
    input  logic                     ld_rsp_err_i,

    // Writeback to ROB.
    output logic                     wb_valid_o,
    output logic [ROB_IDX_WIDTH-1:0] wb_rob_idx_o,
    output logic [XLEN-1:0]          wb_data_o,
    output logic                     wb_exception_o,
    output logic [4:0]               wb_ecause_o,
    input  logic                     wb_ready_i
);

    lsu_agu_if #(
        .XLEN(XLEN), .PLEN(PLEN), .ROB_IDX_WIDTH(ROB_IDX_WIDTH), .SB_ID_WIDTH(SB_ID_WIDTH)
    ) agu_bus ();

    lsu_wb_if #(
        .XLEN(XLEN), .PLEN(PLEN), .ROB_IDX_WIDTH(ROB_IDX_WIDTH), .SB_ID_WIDTH(SB_ID_WIDTH)
    ) wb_bus ();

    lsu_agu #(
        .XLEN(XLEN), .PLEN(PLEN), .ROB_IDX_WIDTH(ROB_IDX_WIDTH), .SB_ID_WIDTH(SB_ID_WIDTH)
    ) u_agu (
        .clk_i, .arst_n_i, .flush_i,
        .req_valid_i, .req_ready_o, .op_i, .imm_i, .rs1_data_i, .rs2_data_i,
        .rob_tag_i, .sb_id_i,
        .sb_ex_valid_o, .sb_ex_sb_id_o, .sb_ex_addr_o, .sb_ex_data_o, .sb_ex_op_o,
        .agu(agu_bus.agu)
    );

    lsu_load_unit #(
        .XLEN(XLEN), .PLEN(PLEN), .ROB_IDX_WIDTH(ROB_IDX_WIDTH), .SB_ID_WIDTH(SB_ID_WIDTH)
    ) u_load_unit (
        .clk_i, .arst_n_i, .flush_i,
        .agu(agu_bus.load),
        .sb_load_addr_o, .sb_load_hit_i, .sb_load_data_i,
        .ld_req_valid_o, .ld_req_ready_i, .ld_req_addr_o, .ld_req_op_o,
        .ld_rsp_valid_i, .ld_rsp_ready_o, .ld_rsp_data_i, .ld_rsp_err_i,
        .wb(wb_bus.src)
    );

    lsu_writeback #(
        .XLEN(XLEN), .PLEN(PLEN), .ROB_IDX_WIDTH(ROB_IDX_WIDTH), .SB_ID_WIDTH(SB_ID_WIDTH)
    ) u_writeback (
        .clk_i, .arst_n_i, .flush_i,
        .wb(wb_bus.dst),
        .wb_valid_o, .wb_rob_idx_o, .wb_data_o, .wb_exception_o, .wb_ecause_o,
        .wb_ready_i
    );

endmodule

// File: test/lsu_assertions.sv
// LSU handshake assertions
`timescale 1ns/10ps

module lsu_assertions #(
    parameter int XLEN          = 32,
    parameter int PLEN          = 32,
    parameter int ROB_IDX_WIDTH = 6
) (
    input logic                     clk_i,
    input logic                     arst_n_i,
    input logic                     flush_i,
    input logic                     req_ready_o,
    input logic                     sb_ex_valid_o,
    input logic                     ld_req_valid_o,
    input logic                     ld_req_ready_i,
    input logic [PLEN-1:0]          ld_req_addr_o,
    input logic                     ld_rsp_ready_o,
    input logic                     wb_valid_o,
    input logic                     wb_ready_i,
    input logic [ROB_IDX_WIDTH-1:0] wb_rob_idx_o,
    input logic [XLEN-1:0]          wb_data_o,
    input logic                     wb_exception_o,
    input logic [4:0]               wb_ecause_o
);

    int fail_count = 0;

    // ********************
    // Handshakes
    // ********************

    a_wb_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        wb_valid_o && !wb_ready_i && !flush_i |=> wb_valid_o &&
        $stable({wb_rob_idx_o, wb_data_o, wb_exception_o, wb_ecause_o}))
        else begin
            fail_count++;
            $error("wb payload changed before ready");
        end

    a_ld_req_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        ld_req_valid_o && !ld_req_ready_i && !flush_i |=> ld_req_valid_o &&
        $stable(ld_req_addr_o))
        else begin
            fail_count++;
            $error("cache request dropped before ready");
        end

    a_sb_pulse: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        sb_ex_valid_o |=> !sb_ex_valid_o)
        else begin
            fail_count++;
            $error("store buffer write held two cycles");
        end

    // Control outputs in reset.
    a_reset: assert property (@(posedge clk_i) !arst_n_i |-> req_ready_o &&
        !sb_ex_valid_o && !ld_req_valid_o && !ld_rsp_ready_o && !wb_valid_o)
        else begin
            fail_count++;
            $error("control outputs wrong in reset");
        end

endmodule

bind lsu_top lsu_assertions #(
    .XLEN(XLEN), .PLEN(PLEN), .ROB_IDX_WIDTH(ROB_IDX_WIDTH)
) u_lsu_assertions (.*);

// File: test/lsu_tb.sv
// LSU testbench
`timescale 1ns/10ps

module lsu_tb import lsu_pkg::*; ();

    localparam int XLEN       = 32;
    localparam int PLEN       = 32;
    localparam int ROB_W      = 6;
    localparam int SBID_W     = 4;
    localparam int CLK_PERIOD = 40;
    localparam int NUM_ROWS   = 14;
    localparam int WATCHDOG   = (8 + NUM_ROWS * 40) * CLK_PERIOD;

    typedef struct {
        lsu_op_e     op;
        logic [31:0] rs1;
        logic [31:0] imm;
        logic [31:0] rs2;
        logic [5:0]  rob;
        logic [3:0]  sb_id;
        logic        hit;
        logic [31:0] fwd;
        logic [31:0] cdata;
        logic        cerr;
        logic        flush;
    } row_t;

    logic clk_i, arst_n_i, flush_i;
    logic req_valid_i, req_ready_o;
    lsu_op_e op_i, sb_ex_op_o, ld_req_op_o;
    logic [XLEN-1:0] imm_i, rs1_data_i, rs2_data_i, sb_ex_data_o, sb_load_data_i;
    logic [XLEN-1:0] ld_rsp_data_i, wb_data_o;
    logic [ROB_W-1:0] rob_tag_i, wb_rob_idx_o;
    logic [SBID_W-1:0] sb_id_i, sb_ex_sb_id_o;
    logic sb_ex_valid_o, sb_load_hit_i, ld_req_valid_o, ld_req_ready_i;
    logic [PLEN-1:0] sb_ex_addr_o, sb_load_addr_o, ld_req_addr_o;
    logic ld_rsp_valid_i, ld_rsp_ready_o, ld_rsp_err_i;
    logic wb_valid_o, wb_exception_o, wb_ready_i;
    logic [4:0] wb_ecause_o;
    logic [31:0] lfsr = 32'hd4a;
    row_t rows [NUM_ROWS];

    lsu_top #(.XLEN(XLEN), .PLEN(PLEN), .ROB_IDX_WIDTH(ROB_W), .SB_ID_WIDTH(SBID_W)) UUT (.*);

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    initial begin
        #(WATCHDOG);
        $display("Timeout: the DUT stopped answering and the run did not finish in time.");
        $display("ERRORS FOUND");
        $fatal(1);
    end

    initial begin
        wait (UUT.u_lsu_assertions.fail_count != 0);
        stop_on_assertion();
    end

    // Fibonacci LFSR with taps 32 22 2 1.
    function automatic logic next_bit();
        logic fb;
        fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] expect_data(input lsu_op_e op, input logic [1:0] off,
                                                input logic [31:0] src);
        lsu_word_u u;
        logic [15:0] h;
        u.word = src;
        h = {u.lane[off | 2'd1], u.lane[off & 2'd2]};
        case (op)
            LB:      return 32'($signed(u.lane[off]));
            LBU:     return 32'(u.lane[off]);
            LH:      return 32'($signed(h));
            LHU:     return 32'(h);
            default: return u.word;
        endcase
    endfunction

    task automatic report_error(input string msg);
        $display("error at %0t ns: %s", $time, msg);
        $display("ERRORS FOUND");
        $fatal(1);
    endtask

    task automatic stop_on_assertion();
        $display("A bound handshake or reset assertion failed during the run.");
        $display("ERRORS FOUND");
        $fatal(1);
    endtask

    task automatic check_wb(input logic [ROB_W-1:0] rob_exp, input logic [XLEN-1:0] data_exp,
                            input logic exc_exp, input logic [4:0] cause_exp);
        if (wb_rob_idx_o !== rob_exp || wb_data_o !== data_exp || wb_exception_o !== exc_exp ||
            (exc_exp && wb_ecause_o !== cause_exp)) begin
            report_error($sformatf(
                "writeback rob %0d data %h exc %b cause %0d, expected %0d %h %b %0d",
                wb_rob_idx_o, wb_data_o, wb_exception_o, wb_ecause_o,
                rob_exp, data_exp, exc_exp, cause_exp));
        end
    endtask

    task automatic check_sb_write(input lsu_op_e op_exp, input logic [PLEN-1:0] addr_exp,
                                  input logic [XLEN-1:0] data_exp,
                                  input logic [SBID_W-1:0] id_exp);
        if (sb_ex_op_o !== op_exp || sb_ex_addr_o !== addr_exp || sb_ex_data_o !== data_exp ||
            sb_ex_sb_id_o !== id_exp) begin
            report_error($sformatf("store write %s %h %h id %0d, expected %s %h %h id %0d",
                sb_ex_op_o.name(), sb_ex_addr_o, sb_ex_data_o, sb_ex_sb_id_o,
                op_exp.name(), addr_exp, data_exp, id_exp));
        end
    endtask

    task automatic check_ld_req(input lsu_op_e op_exp, input logic [PLEN-1:0] addr_exp);
        if (ld_req_op_o !== op_exp || ld_req_addr_o !== addr_exp) begin
            report_error($sformatf("cache request %s %h, expected %s %h",
                ld_req_op_o.name(), ld_req_addr_o, op_exp.name(), addr_exp));
        end
    endtask

    // Only the word part matters for forwarding.
    task automatic check_fwd_addr(input logic [PLEN-1:0] addr_exp);
        if (sb_load_addr_o[PLEN-1:2] !== addr_exp[PLEN-1:2]) begin
            report_error($sformatf("forwarding address %h, expected word of %h",
                sb_load_addr_o, addr_exp));
        end
    endtask

    task automatic run_row(input int r);
        row_t rw;
        logic [31:0] addr, exp_data;
        logic al, is_st, exp_sb, exp_cache, exp_exc;
        logic [4:0] exp_cause;
        int c, first_wb, n_sb, n_req, n_wb, delay, tail;
        logic req_done, rsp_on, rsp_done, flushed;
        rw = rows[r];
        addr = rw.rs1 + rw.imm;
        al = op_aligned(rw.op, addr[1:0]);
        is_st = op_is_store(rw.op);
        exp_sb = is_st & al;
        exp_cache = !is_st & al & !rw.hit;
        exp_exc = !al | (exp_cache & rw.cerr);
        exp_cause = !al ? (is_st ? CAUSE_ST_MISALIGN : CAUSE_LD_MISALIGN) : CAUSE_LD_FAULT;
        exp_data = (is_st || exp_exc) ? 32'd0 :
                   expect_data(rw.op, addr[1:0], rw.hit ? rw.fwd : rw.cdata);
        @(negedge clk_i);
        req_valid_i = 1'b1;
        op_i = rw.op;
        rs1_data_i = rw.rs1;
        imm_i = rw.imm;
        rs2_data_i = rw.rs2;
        rob_tag_i = rw.rob;
        sb_id_i = rw.sb_id;
        sb_load_hit_i = rw.hit;
        sb_load_data_i = rw.fwd;
        do @(posedge clk_i); while (!req_ready_o);
        c = 0;
        first_wb = -1;
        n_sb = 0;
        n_req = 0;
        n_wb = 0;
        delay = 0;
        tail = 0;
        req_done = 1'b0;
        rsp_on = 1'b0;
        rsp_done = 1'b0;
        flushed = 1'b0;
        while (tail < 6) begin
            @(negedge clk_i);
            req_valid_i = 1'b0;
            flush_i = 1'b0;
            ld_req_ready_i = next_bit();
            wb_ready_i = next_bit();
            if (req_done && !rsp_done) begin
                if (rw.flush && !flushed) begin
                    flush_i = 1'b1;  // Kill the load after its request.
                    flushed = 1'b1;
                end else if (delay > 0) begin
                    delay--;
                end else begin
                    rsp_on = 1'b1;
                end
            end
            ld_rsp_valid_i = rsp_on;
            ld_rsp_data_i = rw.cdata;
            ld_rsp_err_i = rw.cerr;
            @(posedge clk_i);
            c++;
            if (c == 1 && al && !is_st) check_fwd_addr(addr);
            if (sb_ex_valid_o) begin
                n_sb++;
                check_sb_write(rw.op, addr, rw.rs2, rw.sb_id);
                if (c != 1) report_error("store buffer write came in the wrong cycle");
            end
            if (ld_req_valid_o && ld_req_ready_i) begin
                n_req++;
                req_done = 1'b1;
                delay = {next_bit(), next_bit()};
                check_ld_req(rw.op, addr);
            end
            if (ld_rsp_valid_i && ld_rsp_ready_o) begin
                rsp_done = 1'b1;
                rsp_on = 1'b0;
            end
            if (wb_valid_o && first_wb < 0) first_wb = c;
            if (wb_valid_o && wb_ready_i) begin
                n_wb++;
                check_wb(rw.rob, exp_data, exp_exc, exp_cause);
            end
            if (n_wb > 0 || (rw.flush && rsp_done)) tail++;
        end
        if (n_sb != int'(exp_sb)) report_error("wrong number of store buffer writes");
        if (n_req != int'(exp_cache)) report_error("wrong number of cache requests");
        if (n_wb != int'(!rw.flush)) report_error("wrong number of writebacks");
        if (!exp_cache && first_wb != 3) report_error("writeback latency is not 3 cycles");
    endtask

    initial begin
        // op, rs1, imm, rs2, rob, sb id, hit, fwd, cache data, cache err, flush.
        rows[0]  = '{LB,  32'h1000, 32'h1, 32'h0, 6'd1, 4'd0, 0, 32'h0, 32'h1234_8056, 0, 0};
        rows[1]  = '{LBU, 32'h1000, 32'h3, 32'h0, 6'd2, 4'd0, 0, 32'h0, 32'h1234_8056, 0, 0};
        rows[2]  = '{LH,  32'h1000, 32'h2, 32'h0, 6'd3, 4'd0, 0, 32'h0, 32'h9abc_1234, 0, 0};
        rows[3]  = '{LHU, 32'h1004, 32'hffff_fffe, 32'h0, 6'd4, 4'd0, 0, 32'h0,
                     32'h9abc_1234, 0, 0};
        rows[4]  = '{LW,  32'h1008, 32'h0, 32'h0, 6'd5, 4'd0, 0, 32'h0, 32'hdead_beef, 0, 0};
        rows[5]  = '{LH,  32'h2000, 32'h2, 32'h0, 6'd6, 4'd0, 1, 32'hcafe_f00d, 32'h0, 0, 0};
        rows[6]  = '{LBU, 32'h2000, 32'h0, 32'h0, 6'd7, 4'd0, 1, 32'hcafe_f00d, 32'h0, 0, 0};
        rows[7]  = '{SW,  32'h3000, 32'h4, 32'h1122_3344, 6'd8, 4'd3, 0, 32'h0, 32'h0, 0, 0};
        rows[8]  = '{SB,  32'h3000, 32'h7, 32'h0000_00aa, 6'd9, 4'd4, 0, 32'h0, 32'h0, 0, 0};
        rows[9]  = '{SH,  32'h3000, 32'h1, 32'h0000_bbbb, 6'd10, 4'd5, 0, 32'h0, 32'h0, 0, 0};
        rows[10] = '{LW,  32'h1000, 32'h2, 32'h0, 6'd11, 4'd0, 0, 32'h0, 32'h0, 0, 0};
        rows[11] = '{LH,  32'h4000, 32'h0, 32'h0, 6'd12, 4'd0, 0, 32'h0, 32'h5555_5555, 1, 0};
        rows[12] = '{LW,  32'h5000, 32'h0, 32'h0, 6'd13, 4'd0, 0, 32'h0, 32'h7777_7777, 0, 1};
        rows[13] = '{LBU, 32'h5000, 32'h0, 32'h0, 6'd14, 4'd0, 0, 32'h0, 32'h0000_00a5, 0, 0};
        arst_n_i = 1'b0;
        flush_i = 1'b0;
        req_valid_i = 1'b0;
        op_i = LW;
        imm_i = '0;
        rs1_data_i = '0;
        rs2_data_i = '0;
        rob_tag_i = '0;
        sb_id_i = '0;
        sb_load_hit_i = 1'b0;
        sb_load_data_i = '0;
        ld_req_ready_i = 1'b0;
        ld_rsp_valid_i = 1'b0;
        ld_rsp_data_i = '0;
        ld_rsp_err_i = 1'b0;
        wb_ready_i = 1'b0;
        repeat (4) @(posedge clk_i);
        @(negedge clk_i);
        arst_n_i = 1'b1;
        for (int r = 0; r < NUM_ROWS; r++) begin
            run_row(r);
        end
        @(negedge clk_i);
        if (UUT.u_lsu_assertions.fail_count != 0) begin
            stop_on_assertion();
        end else begin
            $display("NO ERRORS");
            $finish;
        end
    end

endmodule

// File: lsu.f
rtl/lsu_pkg.sv
rtl/lsu_agu_if.sv
rtl/lsu_wb_if.sv
rtl/lsu_agu.sv
rtl/lsu_load_unit.sv
rtl/lsu_writeback.sv
rtl/lsu_top.sv
test/lsu_assertions.sv
test/lsu_tb.sv
